//--- rtl/cpuPkg.sv
package cpuPkg;
	localparam int dataWidth = 16; // Data word
	localparam int addrWidth = 10; // RAM and program space
	localparam int regAddrWidth = 5; // 32 registers
	localparam int opcodeWidth = 6;

	typedef logic [dataWidth-1:0] word_t;
	typedef logic [addrWidth-1:0] addr_t;
	typedef logic [regAddrWidth-1:0] regAddr_t;

	localparam regAddr_t resultReg = regAddr_t'(1); // Implicit destination, register 1

	typedef enum logic [opcodeWidth-1:0] {
		opNop = 6'h00,
		opLw = 6'h01, // r1 = ram[addr]
		opSw = 6'h02, // ram[addr] = r1
		opMv = 6'h03, // rB = rA
		opBgz = 6'h04, // Branch if r1 nonzero
		opBez = 6'h05, // Branch if r1 zero
		opJmp = 6'h06,
		opSlt = 6'h09,
		opSlti = 6'h0a,
		opSeq = 6'h0b, // Sets on not equal
		opSeqi = 6'h0c,
		opLim = 6'h0d, // r1 = 10 bit immediate
		opSl = 6'h0e,
		opSr = 6'h0f,
		opAdd = 6'h10,
		opSub = 6'h11,
		opAddi = 6'h15,
		opSubi = 6'h16,
		opNot = 6'h1a, // rB = ~rA
		opXor = 6'h1b,
		opOr = 6'h1c,
		opAnd = 6'h1d,
		opLwr = 6'h1e, // rB = ram[rA]
		opSwr = 6'h1f, // ram[rB] = rA
		opSi = 6'h20, // rA = input bus
		opSli = 6'h21,
		opSri = 6'h22
	} opcode_t;

	typedef enum logic [3:0] {
		aluAdd = 4'b0001,
		aluSub = 4'b0010,
		aluAnd = 4'b0011,
		aluOr = 4'b0100,
		aluXor = 4'b0101,
		aluNot = 4'b0110, // Not of a
		aluShiftLeft = 4'b1010,
		aluShiftRight = 4'b1011,
		aluPassA = 4'b1100,
		aluPassB = 4'b1101,
		aluSetNotEqual = 4'b1110,
		aluSetLess = 4'b1111 // Unsigned
	} aluOp_t;

	typedef enum logic [1:0] {srcAReg = 2'b00, srcAInBus = 2'b10} srcA_t;
	typedef enum logic [1:0] {srcBReg = 2'b00, srcBRam = 2'b01, srcBImm = 2'b10} srcB_t;
	typedef enum logic {ramAddrImm = 1'b0, ramAddrReg = 1'b1} ramAddrSel_t;

	typedef struct packed {
		regAddr_t regA; // Upper 5 bits
		regAddr_t regB;
	} regPair_t;

	// Operand field is either one address or two register indices
	typedef union packed {
		addr_t addr;
		regPair_t regs;
	} operand_u;

	typedef struct packed {
		opcode_t opcode;
		operand_u operand;
	} instr_t;

	typedef struct packed {
		logic ramWe;
		logic regWe;
		regAddr_t regWAddr;
		regAddr_t regAAddr;
		regAddr_t regBAddr;
		srcA_t srcA;
		srcB_t srcB;
		ramAddrSel_t ramAddrSel;
		aluOp_t aluOp;
		addr_t imm; // Zero extended into operand B
	} ctrl_t;
endpackage

//--- rtl/alu.sv
`timescale 1ns/1ns

module alu import cpuPkg::*; (
	input ctrl_t ctrl, // Mode from aluOp
	input word_t a,
	input word_t b,
	output word_t result,
	output logic zero
);
	logic [3:0] shamt; // Shift amount

	assign shamt = b[3:0];

	always_comb begin
		case (ctrl.aluOp)
			aluPassA: result = a;
			aluPassB: result = b;
			aluAdd: result = a + b; // Wraps
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr: result = a | b;
			aluXor: result = a ^ b;
			aluNot: result = ~a;
			aluShiftLeft: result = a << shamt;
			aluShiftRight: result = a >> shamt; // Logical
			aluSetLess: result = word_t'(a < b); // Unsigned compare
			aluSetNotEqual: result = word_t'(a != b);
			default: result = '0; // Inactive control word
		endcase
	end

	assign zero = (result == '0); // Used for BEZ and BGZ
endmodule

//--- rtl/ctrlUnit.sv
`timescale 1ns/1ns

module ctrlUnit import cpuPkg::*; (
	input instr_t instr, // From program memory
	input logic zero, // ALU zero flag, reflects r1 on branches
	input logic rstN,
	output ctrl_t ctrl,
	output logic branch, // Load target into pc
	output addr_t target
);
	aluOp_t aluMode; // Mode shared by register and immediate forms
	regAddr_t fieldA;
	regAddr_t fieldB;

	assign fieldA = instr.operand.regs.regA; // Register view of the operand
	assign fieldB = instr.operand.regs.regB;

	always_comb begin
		case (instr.opcode)
			opSlt, opSlti: aluMode = aluSetLess;
			opSeq, opSeqi: aluMode = aluSetNotEqual;
			opSl, opSli: aluMode = aluShiftLeft;
			opSr, opSri: aluMode = aluShiftRight;
			opAdd, opAddi: aluMode = aluAdd;
			opSub, opSubi: aluMode = aluSub;
			opAnd: aluMode = aluAnd;
			opOr: aluMode = aluOr;
			opXor: aluMode = aluXor; // Writes r1, never RAM
			default: aluMode = aluPassA;
		endcase
	end

	always_comb begin
		ctrl = '0; // NOP, JMP and unknown opcodes stay inactive
		case (instr.opcode)
			opLw: begin
				ctrl.regWe = 1'b1;
				ctrl.regWAddr = resultReg;
				ctrl.srcB = srcBRam; // RAM data through B
				ctrl.aluOp = aluPassB;
				ctrl.imm = instr.operand.addr; // RAM address
			end
			opSw: begin
				ctrl.ramWe = 1'b1;
				ctrl.regBAddr = resultReg; // Store data on port B
				ctrl.imm = instr.operand.addr;
			end
			opMv: begin
				ctrl.regWe = 1'b1;
				ctrl.regWAddr = fieldB;
				ctrl.regAAddr = fieldA;
				ctrl.aluOp = aluPassA;
			end
			opBgz, opBez: begin
				ctrl.regAAddr = resultReg; // r1 through the ALU sets zero
				ctrl.aluOp = aluPassA;
			end
			opLim: begin
				ctrl.regWe = 1'b1;
				ctrl.regWAddr = resultReg;
				ctrl.srcB = srcBImm;
				ctrl.aluOp = aluPassB;
				ctrl.imm = instr.operand.addr; // Full 10 bit immediate
			end
			opSlt, opSeq, opSl, opSr, opAdd, opSub, opAnd, opOr, opXor: begin
				ctrl.regWe = 1'b1;
				ctrl.regWAddr = resultReg;
				ctrl.regAAddr = fieldA;
				ctrl.regBAddr = fieldB;
				ctrl.aluOp = aluMode;
			end
			opSlti, opSeqi, opSli, opSri, opAddi, opSubi: begin
				ctrl.regWe = 1'b1;
				ctrl.regWAddr = resultReg;
				ctrl.regAAddr = fieldA;
				ctrl.srcB = srcBImm;
				ctrl.aluOp = aluMode;
				ctrl.imm = addr_t'(fieldB); // 5 bit immediate
			end
			opNot: begin
				ctrl.regWe = 1'b1;
				ctrl.regWAddr = fieldB;
				ctrl.regAAddr = fieldA;
				ctrl.aluOp = aluNot;
			end
			opLwr: begin
				ctrl.regWe = 1'b1;
				ctrl.regWAddr = fieldB;
				ctrl.regAAddr = fieldA; // Pointer register
				ctrl.srcB = srcBRam;
				ctrl.ramAddrSel = ramAddrReg;
				ctrl.aluOp = aluPassB;
			end
			opSwr: begin
				ctrl.ramWe = 1'b1;
				ctrl.regAAddr = fieldB; // Address from rB
				ctrl.regBAddr = fieldA; // Value from rA
				ctrl.ramAddrSel = ramAddrReg;
			end
			opSi: begin
				ctrl.regWe = 1'b1;
				ctrl.regWAddr = fieldA; // Low field ignored
				ctrl.srcA = srcAInBus;
				ctrl.aluOp = aluPassA;
			end
			default: ;
		endcase
		ctrl.ramWe = ctrl.ramWe & rstN; // No writes in reset
		ctrl.regWe = ctrl.regWe & rstN;
	end

	// Kept apart from the decode so zero does not feed back into ctrl
	always_comb begin
		case (instr.opcode)
			opJmp: branch = 1'b1;
			opBez: branch = zero;
			opBgz: branch = ~zero; // Any nonzero r1
			default: branch = 1'b0;
		endcase
	end

	assign target = instr.operand.addr; // Address view of the operand
endmodule

//--- rtl/progCounter.sv
`timescale 1ns/1ns

module progCounter import cpuPkg::*; (
	input logic clk,
	input logic rstN,
	input logic branch, // Taken branch or jump
	input addr_t target,
	output addr_t pc
);
	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0;
		end else if (branch) begin
			pc <= target;
		end else begin
			pc <= pc + addr_t'(1); // Wraps at 1024
		end
	end
endmodule

//--- rtl/regFile.sv
`timescale 1ns/1ns

module regFile import cpuPkg::*; (
	input logic clk,
	input logic rstN,
	input ctrl_t ctrl, // Read and write indices, write enable
	input word_t wData, // ALU result
	output word_t rdA,
	output word_t rdB
);
	word_t regs [2**regAddrWidth]; // 32 x 16

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 2**regAddrWidth; i++) begin
				regs[i] <= '0; // Whole file clears
			end
		end else if (ctrl.regWe) begin
			regs[ctrl.regWAddr] <= wData;
		end
	end

	// Combinational reads, old value until the edge
	assign rdA = regs[ctrl.regAAddr];
	assign rdB = regs[ctrl.regBAddr]; // Also the RAM write data
endmodule

//--- rtl/operandSel.sv
`timescale 1ns/1ns

module operandSel import cpuPkg::*; (
	input ctrl_t ctrl,
	input word_t rdA,
	input word_t rdB,
	input word_t inBus, // External input port
	input word_t ramRData, // Combinational RAM read
	output word_t aluA,
	output word_t aluB,
	output addr_t ramAddr
);
	always_comb begin
		case (ctrl.srcA)
			srcAInBus: aluA = inBus; // SI
			default: aluA = rdA;
		endcase
	end

	always_comb begin
		case (ctrl.srcB)
			srcBRam: aluB = ramRData; // LW, LWR
			srcBImm: aluB = word_t'(ctrl.imm); // Zero extended
			default: aluB = rdB;
		endcase
	end

	// Register pointer for LWR and SWR, else the instruction address
	always_comb begin
		if (ctrl.ramAddrSel == ramAddrReg) begin
			ramAddr = rdA[addrWidth-1:0];
		end else begin
			ramAddr = ctrl.imm;
		end
	end
endmodule

//--- rtl/cpuTop.sv
`timescale 1ns/1ns

module cpuTop import cpuPkg::*; (
	input logic clk,
	input logic rstN,
	input instr_t instr, // Program memory read data at pc
	input word_t inBus,
	input word_t ramRData,
	output addr_t pc,
	output addr_t ramAddr,
	output word_t ramWData,
	output logic ramWe // Store at the next rising edge
);
	ctrl_t ctrl;
	logic branch;
	logic zero;
	addr_t target;
	word_t rdA;
	word_t rdB;
	word_t aluA;
	word_t aluB;
	word_t result; // Register write data

	assign ramWData = rdB;
	assign ramWe = ctrl.ramWe;

	ctrlUnit uCtrl (
		.instr(instr),
		.zero(zero),
		.rstN(rstN),
		.ctrl(ctrl),
		.branch(branch),
		.target(target)
	);

	progCounter uPc (
		.clk(clk),
		.rstN(rstN),
		.branch(branch),
		.target(target),
		.pc(pc)
	);

	regFile uRegs (
		.clk(clk),
		.rstN(rstN),
		.ctrl(ctrl),
		.wData(result),
		.rdA(rdA),
		.rdB(rdB)
	);

	operandSel uSel (
		.ctrl(ctrl),
		.rdA(rdA),
		.rdB(rdB),
		.inBus(inBus),
		.ramRData(ramRData),
		.aluA(aluA),
		.aluB(aluB),
		.ramAddr(ramAddr)
	);

	alu uAlu (
		.ctrl(ctrl),
		.a(aluA),
		.b(aluB),
		.result(result),
		.zero(zero)
	);
endmodule

//--- sim/cpuTop_props.sv
`timescale 1ns/1ns

module cpuTopProps import cpuPkg::*; (
	input logic clk,
	input logic rstN,
	input instr_t instr,
	input addr_t pc,
	input logic ramWe
);
	logic isBranch; // JMP, BEZ, BGZ may load the target

	assign isBranch = instr.opcode inside {opJmp, opBez, opBgz};

	noWriteInReset: assert property (@(posedge clk) !rstN |-> !ramWe)
		else $error("RAM write enable high while reset is active");

	pcClearedByReset: assert property (@(posedge clk) !rstN |=> pc == '0)
		else $error("pc not zero in the cycle after reset");

	pcSteps: assert property (@(posedge clk) disable iff (!rstN)
		!isBranch |=> pc == addr_t'($past(pc) + addr_t'(1))) // Wraps at 1024
		else $error("pc did not advance by one on a non-branch opcode");
endmodule

bind cpuTop cpuTopProps uProps (
	.clk(clk),
	.rstN(rstN),
	.instr(instr),
	.pc(pc),
	.ramWe(ramWe)
);

//--- sim/cpuChecker.sv
`timescale 1ns/1ns

module cpuChecker import cpuPkg::*; (
	input logic clk,
	input logic rstN,
	input logic [1:0] phase, // 0 reset, 1 random, 2 dump, 3 done
	input instr_t instr,
	input word_t inBus,
	input addr_t pc,
	input addr_t ramAddr,
	input word_t ramWData,
	input logic ramWe,
	output int errTotal,
	output logic reported // Summary lines printed
);
	word_t mRegs [2**regAddrWidth]; // Model state
	word_t mRam [2**addrWidth];
	addr_t mPc;
	logic afterReset;
	logic condBranch; // Last instruction was BEZ or BGZ
	logic [1:0] lastPhase;
	int checks [8]; // Per behavior
	int errs [8];
	int checkTotal;

	function automatic word_t ramFill(input addr_t a);
		return {a[5:0], a} ^ 16'h6c39;
	endfunction

	task automatic compare(input int test, input int alsoTest, input string name,
			input word_t got, input word_t exp);
		checkTotal++;
		checks[3'(test)]++;
		if (alsoTest != 0) checks[3'(alsoTest)]++;
		if (got !== exp) begin
			errTotal++;
			errs[3'(test)]++;
			if (alsoTest != 0) errs[3'(alsoTest)]++;
			$display("MISMATCH %s at model pc 0x%03h: got 0x%04h, expected 0x%04h",
				name, mPc, got, exp);
		end
	endtask

	task automatic reportTest(input int test, input string name);
		$display("Test %0d %s: %0d checks, %0d errors, %s", test, name, checks[3'(test)],
			errs[3'(test)], (errs[3'(test)] == 0) ? "passed" : "failed");
	endtask

	// One instruction of the ISA, stores checked before state moves on
	task automatic step();
		regAddr_t ra;
		regAddr_t rb;
		addr_t ad;
		word_t va;
		word_t vb;
		word_t imm5;
		logic expWe;
		addr_t expAddr;
		word_t expData;
		addr_t nextPc;
		int storeTest;
		ra = instr.operand.regs.regA;
		rb = instr.operand.regs.regB;
		ad = instr.operand.addr;
		va = mRegs[ra];
		vb = mRegs[rb];
		imm5 = word_t'(rb); // Zero extended low field
		nextPc = mPc + addr_t'(1);
		storeTest = (phase == 2'd2) ? 5 : 3;
		expWe = (instr.opcode == opSw) || (instr.opcode == opSwr);
		expAddr = (instr.opcode == opSw) ? ad : vb[addrWidth-1:0]; // SWR address in rB
		expData = (instr.opcode == opSw) ? mRegs[resultReg] : va;
		compare(storeTest, 0, "ramWe", word_t'(ramWe), word_t'(expWe));
		if (expWe) begin
			compare(storeTest, 0, "ramAddr", word_t'(ramAddr), word_t'(expAddr));
			compare(storeTest, (phase == 2'd1) ? 4 : 0, "ramWData", ramWData, expData);
			mRam[expAddr] = expData;
		end
		case (instr.opcode)
			opLw: mRegs[resultReg] = mRam[ad];
			opMv: mRegs[rb] = va;
			opBgz: if (mRegs[resultReg] != '0) nextPc = ad;
			opBez: if (mRegs[resultReg] == '0) nextPc = ad;
			opJmp: nextPc = ad;
			opLim: mRegs[resultReg] = word_t'(ad);
			opAdd: mRegs[resultReg] = va + vb;
			opSub: mRegs[resultReg] = va - vb;
			opAddi: mRegs[resultReg] = va + imm5;
			opSubi: mRegs[resultReg] = va - imm5;
			opSlt: mRegs[resultReg] = (va < vb) ? 16'd1 : 16'd0; // Unsigned
			opSlti: mRegs[resultReg] = (va < imm5) ? 16'd1 : 16'd0;
			opSeq: mRegs[resultReg] = (va != vb) ? 16'd1 : 16'd0; // Set on not equal
			opSeqi: mRegs[resultReg] = (va != imm5) ? 16'd1 : 16'd0;
			opAnd: mRegs[resultReg] = va & vb;
			opOr: mRegs[resultReg] = va | vb;
			opXor: mRegs[resultReg] = va ^ vb;
			opNot: mRegs[rb] = ~va;
			opSl: mRegs[resultReg] = va << vb[3:0];
			opSr: mRegs[resultReg] = va >> vb[3:0];
			opSli: mRegs[resultReg] = va << imm5[3:0];
			opSri: mRegs[resultReg] = va >> imm5[3:0];
			opLwr: mRegs[rb] = mRam[va[addrWidth-1:0]];
			opSi: mRegs[ra] = inBus;
			default: ; // NOP, SW, SWR
		endcase
		condBranch = (instr.opcode == opBez) || (instr.opcode == opBgz);
		mPc = nextPc;
	endtask

	initial begin
		errTotal = 0;
		checkTotal = 0;
		reported = 1'b0;
		lastPhase = 2'd0;
		for (int i = 0; i < 8; i++) begin
			checks[3'(i)] = 0;
			errs[3'(i)] = 0;
		end
		for (int a = 0; a < 2**addrWidth; a++) begin
			mRam[addr_t'(a)] = ramFill(addr_t'(a)); // Same start image as the testbench RAM
		end
	end

	// Inputs settle 1 ns after the rising edge, so the falling edge sees stable values
	always @(negedge clk) begin
		if (!rstN) begin
			compare(1, 0, "ramWe", word_t'(ramWe), 16'h0);
			for (int i = 0; i < 2**regAddrWidth; i++) mRegs[regAddr_t'(i)] = '0;
			mPc = '0;
			afterReset = 1'b1;
			condBranch = 1'b0;
		end else if (phase == 2'd1 || phase == 2'd2) begin
			if (afterReset) begin
				compare(1, 0, "pc", word_t'(pc), 16'h0);
				reportTest(1, "reset");
				afterReset = 1'b0;
			end
			if (phase == 2'd2 && lastPhase == 2'd1) begin
				reportTest(3, "random stores");
				reportTest(4, "register results");
			end
			compare(2, (condBranch && phase == 2'd1) ? 4 : 0, "pc", word_t'(pc), word_t'(mPc));
			step();
		end else if (phase == 2'd3 && !reported) begin
			reportTest(2, "pc sequence");
			reportTest(5, "register dump");
			$display("Totals: %0d checks, %0d errors", checkTotal, errTotal);
			reported = 1'b1;
		end
		lastPhase = phase;
	end
endmodule

//--- sim/cpuTb.sv
`timescale 1ns/1ns

module cpuTb import cpuPkg::*; ();
	localparam int resetCycles = 3;
	localparam int runLength = 3000; // Total cycles incl. reset and dump
	localparam int dumpLen = 63; // SW of r1, then MV and SW for the other 31
	localparam int randCycles = runLength - resetCycles - dumpLen - 1;
	localparam int timeoutLimit = runLength + 100;
	localparam addr_t dumpBase = 10'h3e0; // Top 32 RAM words

	logic clk = 1'b0;
	logic rstN;
	instr_t instr;
	word_t inBus;
	word_t ramRData;
	addr_t pc;
	addr_t ramAddr;
	word_t ramWData;
	logic ramWe;
	logic [1:0] phase; // 0 reset, 1 random, 2 dump, 3 done
	int cycle = 0;
	int errTotal;
	logic reported;
	instr_t prog [2**addrWidth]; // Instruction memory
	word_t ram [2**addrWidth]; // Data RAM
	opcode_t otherOps [25] = '{opNop, opLw, opMv, opBgz, opBez, opJmp, opLim, opAdd, opSub,
		opAddi, opSubi, opSlt, opSlti, opSeq, opSeqi, opAnd, opOr, opXor, opNot, opSl, opSr,
		opSli, opSri, opLwr, opSi};

	function automatic word_t ramFill(input addr_t a);
		return {a[5:0], a} ^ 16'h6c39; // Distinct per address
	endfunction

	task automatic buildProgram();
		instr_t ins;
		for (int i = 0; i < 2**addrWidth; i++) begin
			ins.operand.addr = addr_t'($urandom); // Random fields in both views
			if ($urandom_range(7, 0) == 0) begin
				ins.opcode = ($urandom_range(1, 0) == 0) ? opSw : opSwr; // About one in eight
			end else begin
				ins.opcode = otherOps[5'($urandom_range(24, 0))];
			end
			prog[addr_t'(i)] = ins;
		end
	endtask

	// Dump sequence is placed where pc already points, so no jump is needed
	task automatic loadDump(input addr_t start);
		instr_t ins;
		int n;
		ins.opcode = opSw;
		ins.operand.addr = dumpBase + addr_t'(resultReg); // r1 goes out before MV overwrites it
		prog[start] = ins;
		n = 1;
		for (int k = 0; k < 2**regAddrWidth; k++) begin
			if (k != int'(resultReg)) begin
				ins.opcode = opMv;
				ins.operand.regs.regA = regAddr_t'(k);
				ins.operand.regs.regB = resultReg; // Copy rk into r1
				prog[start + addr_t'(n)] = ins;
				ins.opcode = opSw;
				ins.operand.addr = dumpBase + addr_t'(k);
				prog[start + addr_t'(n + 1)] = ins;
				n += 2;
			end
		end
	endtask

	// Store opcodes while in reset, none of them may reach the RAM
	task automatic driveResetStore();
		instr.opcode = ($urandom_range(1, 0) == 0) ? opSw : opSwr;
		instr.operand.addr = addr_t'($urandom);
		inBus = word_t'($urandom);
	endtask

	task automatic driveInputs();
		instr = prog[pc]; // Fetch at current pc
		inBus = word_t'($urandom);
	endtask

	task automatic runCycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			driveInputs();
		end
	endtask

	cpuTop UUT (
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.inBus(inBus),
		.ramRData(ramRData),
		.pc(pc),
		.ramAddr(ramAddr),
		.ramWData(ramWData),
		.ramWe(ramWe)
	);

	cpuChecker uChecker (
		.clk(clk),
		.rstN(rstN),
		.phase(phase),
		.instr(instr),
		.inBus(inBus),
		.pc(pc),
		.ramAddr(ramAddr),
		.ramWData(ramWData),
		.ramWe(ramWe),
		.errTotal(errTotal),
		.reported(reported)
	);

	assign ramRData = ram[ramAddr]; // Combinational read

	always @(posedge clk) begin
		if (ramWe) ram[ramAddr] <= ramWData;
		cycle <= cycle + 1;
	end

	initial begin
		forever #2 clk = ~clk; // 4 ns period
	end

	initial begin
		wait (cycle >= timeoutLimit);
		$display("Timeout: run did not finish within %0d cycles", timeoutLimit);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'h18b0_3fc4));
		rstN = 1'b0;
		driveResetStore();
		phase = 2'd0;
		for (int a = 0; a < 2**addrWidth; a++) begin
			ram[addr_t'(a)] = ramFill(addr_t'(a));
		end
		buildProgram();
		repeat (resetCycles - 1) begin
			@(posedge clk);
			#1;
			driveResetStore();
		end
		@(posedge clk);
		#1;
		rstN = 1'b1; // Released 1 ns after the third edge
		phase = 2'd1;
		driveInputs();
		runCycles(randCycles);
		@(posedge clk);
		#1;
		loadDump(pc);
		phase = 2'd2;
		driveInputs();
		runCycles(dumpLen - 1);
		@(posedge clk);
		#1;
		phase = 2'd3;
		instr = '0;
		wait (reported); // Checker has printed its summary
		if (errTotal == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end
endmodule

//--- vlog.f
rtl/cpuPkg.sv
rtl/alu.sv
rtl/ctrlUnit.sv
rtl/progCounter.sv
rtl/regFile.sv
rtl/operandSel.sv
rtl/cpuTop.sv
sim/cpuTop_props.sv
sim/cpuChecker.sv
sim/cpuTb.sv

//--- run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module cpuTb -f vlog.f -o cpuSim \
	|| { echo "Verilator build failed"; exit 1; }
./obj_dir/cpuSim > sim.log 2>&1 || echo "Simulator returned an error status" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST OK" sim.log || { echo "No pass line found in sim.log"; exit 1; }
